// File: compile.f
udp_echo_pkg.sv
udp_payload_fifo.sv
udp_reply_header.sv
udp_echo_ctrl.sv
udp_echo_top.sv
tb_udp_echo.sv

// File: Makefile
# Verilator flow for the UDP echo core

TOP := tb_udp_echo

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "Test passed" > /dev/null

clean:
	rm -rf obj_dir

// File: tb_udp_echo.sv
// UDP echo testbench
`default_nettype none

module tb_udp_echo
    import udp_echo_pkg::*;
();

    localparam int SEED           = 60772;
    localparam int NUM_FRAMES     = 40;
    localparam int MAX_LEN        = 40;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_LEN + 4) * 4;
    localparam int DRAIN_CYCLES   = 400;

    logic       clk;
    logic       rst;
    udp_hdr_t   rx_hdr;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    axis_beat_t rx_payload;
    logic       rx_payload_valid;
    logic       rx_payload_ready;
    udp_hdr_t   tx_hdr;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready;
    axis_beat_t tx_payload;
    logic       tx_payload_valid;
    logic       tx_payload_ready;

    // Expected replies in output order
    udp_hdr_t   exp_hdr_q[$];
    axis_beat_t exp_beat_q[$];

    logic        long_stalls;
    int unsigned stall_left;
    int          errors;
    int          pass_count;
    int          fail_count;
    int          test_err_start;
    int          cycle_count;

    udp_echo_top dut (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Our IP as source, sender as destination, ports swapped
    function automatic udp_hdr_t expected_reply(udp_hdr_t rx);
        udp_hdr_t r;
        r.src_ip    = LOCAL_IP;
        r.dest_ip   = rx.src_ip;
        r.src_port  = rx.dest_port;
        r.dest_port = rx.src_port;
        r.length    = rx.length;
        return r;
    endfunction

    // Ready sampled at the falling edge, transfer on the next rising edge
    task automatic wait_hdr_taken();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = rx_hdr_ready;
            @(posedge clk);
        end
        #1;
    endtask

    task automatic wait_beat_taken();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = rx_payload_ready;
            @(posedge clk);
        end
        #1;
    endtask

    task automatic send_frame(int len, logic echo);
        udp_hdr_t   hdr;
        axis_beat_t beat;
        logic       bad;
        hdr.src_ip   = $urandom;
        hdr.dest_ip  = $urandom;
        hdr.src_port = 16'($urandom);
        if (echo) begin
            hdr.dest_port = ECHO_PORT;
        end else begin
            hdr.dest_port = 16'($urandom);
            if (hdr.dest_port == ECHO_PORT) begin
                hdr.dest_port = ECHO_PORT + 16'd1;
            end
        end
        hdr.length = 16'(len + 8);
        bad        = 1'($urandom);
        if (echo) begin
            exp_hdr_q.push_back(expected_reply(hdr));
        end
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        wait_hdr_taken();
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            beat.data = 8'($urandom);
            beat.last = (i == len - 1);
            beat.user = beat.last && bad;
            if (echo) begin
                exp_beat_q.push_back(beat);
            end
            rx_payload       = beat;
            rx_payload_valid = 1'b1;
            wait_beat_taken();
            rx_payload_valid = 1'b0;
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic check_idle(int n);
        repeat (n) begin
            @(negedge clk);
            assert (!tx_hdr_valid && !tx_payload_valid) else begin
                $display("ERROR t=%0t tx_hdr_valid/tx_payload_valid expected 0/0 actual %b/%b",
                         $time, tx_hdr_valid, tx_payload_valid);
                errors++;
            end
            assert (!rx_hdr_ready && !rx_payload_ready) else begin
                $display("ERROR t=%0t rx_hdr_ready/rx_payload_ready expected 0/0 actual %b/%b",
                         $time, rx_hdr_ready, rx_payload_ready);
                errors++;
            end
        end
    endtask

    task automatic finish_test(string name, string info);
        if (errors == test_err_start) begin
            pass_count++;
            $display("test %s: PASS %s", name, info);
        end else begin
            fail_count++;
            $display("test %s: FAIL with %0d errors %s", name, errors - test_err_start, info);
        end
        test_err_start = errors;
    endtask

    task automatic run_frames(string name, int n);
        int   len;
        int   echoed;
        int   drain;
        logic echo;
        echoed = 0;
        for (int f = 0; f < n; f++) begin
            len  = 1 + int'($urandom % MAX_LEN);
            echo = ($urandom % 2) == 1;
            if (echo) begin
                echoed++;
            end
            send_frame(len, echo);
        end
        drain = 0;
        while ((exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        assert (exp_hdr_q.size() == 0 && exp_beat_q.size() == 0) else begin
            $display("Replies still missing %0d cycles after the last frame: %0d headers, %0d bytes",
                     DRAIN_CYCLES, exp_hdr_q.size(), exp_beat_q.size());
            errors++;
            exp_hdr_q.delete();
            exp_beat_q.delete();
        end
        // Nothing more may come out once everything expected has
        check_idle(8);
        @(posedge clk);
        #1;
        finish_test(name, $sformatf("(%0d frames, %0d echoed)", n, echoed));
    endtask

    // Random back-pressure on both reply channels
    initial begin
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        stall_left       = 0;
        forever begin
            @(posedge clk);
            #1;
            if (long_stalls && stall_left == 0 && $urandom % 32 == 0) begin
                stall_left = 20 + $urandom % 20;
            end
            if (stall_left > 0) begin
                stall_left--;
                tx_hdr_ready     = 1'b0;
                tx_payload_ready = 1'b0;
            end else begin
                tx_hdr_ready     = ($urandom % 4) != 0;
                tx_payload_ready = ($urandom % 4) != 0;
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            assert (exp_hdr_q.size() != 0) else begin
                $display("Reply header at time %0t with no echoed frame pending", $time);
                errors++;
            end
            if (exp_hdr_q.size() != 0) begin
                assert (tx_hdr == exp_hdr_q[0]) else begin
                    $display("ERROR t=%0t tx_hdr expected %h actual %h",
                             $time, exp_hdr_q[0], tx_hdr);
                    errors++;
                end
                void'(exp_hdr_q.pop_front());
            end
        end
        if (!rst && tx_payload_valid && tx_payload_ready) begin
            assert (exp_beat_q.size() != 0) else begin
                $display("Payload byte at time %0t with no echoed byte pending", $time);
                errors++;
            end
            if (exp_beat_q.size() != 0) begin
                assert (tx_payload == exp_beat_q[0]) else begin
                    $display("ERROR t=%0t tx_payload expected %h/%b/%b actual %h/%b/%b",
                             $time, exp_beat_q[0].data, exp_beat_q[0].last,
                             exp_beat_q[0].user, tx_payload.data, tx_payload.last,
                             tx_payload.user);
                    errors++;
                end
                void'(exp_beat_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        long_stalls      = 1'b0;
        errors           = 0;
        pass_count       = 0;
        fail_count       = 0;
        test_err_start   = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        check_idle(8);
        @(posedge clk);
        #1;
        finish_test("reset_idle", "(no input, no output)");

        run_frames("mixed_frames", NUM_FRAMES / 2);
        long_stalls = 1'b1;
        run_frames("long_stalls", NUM_FRAMES / 2);

        $display("Summary: %0d tests passing, %0d failing", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Cycle limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_echo_top.sv
// UDP echo top level
`default_nettype none

module udp_echo_top
    import udp_echo_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    // Received UDP header
    input  wire udp_hdr_t   rx_hdr,
    input  wire logic       rx_hdr_valid,
    output logic            rx_hdr_ready,

    // Received UDP payload
    input  wire axis_beat_t rx_payload,
    input  wire logic       rx_payload_valid,
    output logic            rx_payload_ready,

    // Reply UDP header
    output udp_hdr_t        tx_hdr,
    output logic            tx_hdr_valid,
    input  wire logic       tx_hdr_ready,

    // Reply UDP payload
    output axis_beat_t      tx_payload,
    output logic            tx_payload_valid,
    input  wire logic       tx_payload_ready
);

    logic hdr_load;
    logic hdr_free;
    logic fifo_wr_valid;
    logic fifo_wr_ready;

    udp_echo_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_dest_port     (rx_hdr.dest_port),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_last  (rx_payload.last),
        .rx_payload_ready (rx_payload_ready),
        .hdr_load         (hdr_load),
        .hdr_free         (hdr_free),
        .fifo_wr_valid    (fifo_wr_valid),
        .fifo_wr_ready    (fifo_wr_ready)
    );

    udp_reply_header u_hdr (
        .clk          (clk),
        .rst          (rst),
        .load         (hdr_load),
        .rx_hdr       (rx_hdr),
        .free         (hdr_free),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready)
    );

    // Received beat goes straight in, only the controller gates it
    udp_payload_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_beat  (rx_payload),
        .wr_valid (fifo_wr_valid),
        .wr_ready (fifo_wr_ready),
        .rd_beat  (tx_payload),
        .rd_valid (tx_payload_valid),
        .rd_ready (tx_payload_ready)
    );

endmodule

`default_nettype wire

// File: udp_echo_ctrl.sv
// UDP echo frame controller
`default_nettype none

module udp_echo_ctrl
    import udp_echo_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    // Received header handshake
    input  wire logic      rx_hdr_valid,
    output logic           rx_hdr_ready,
    input  wire udp_port_t rx_dest_port,

    // Received payload handshake
    input  wire logic      rx_payload_valid,
    input  wire logic      rx_payload_last,
    output logic           rx_payload_ready,

    // Reply header register
    output logic           hdr_load,
    input  wire logic      hdr_free,

    // Payload FIFO write side
    output logic           fifo_wr_valid,
    input  wire logic      fifo_wr_ready
);

    echo_state_t state;
    echo_state_t state_next;
    logic        port_match;
    logic        last_done;

    assign port_match = (rx_dest_port == ECHO_PORT);

    // Final beat of the current frame taken this cycle
    assign last_done = rx_payload_valid && rx_payload_ready && rx_payload_last;

    always_comb begin
        state_next       = state;
        rx_hdr_ready     = 1'b0;
        hdr_load         = 1'b0;
        rx_payload_ready = 1'b0;
        fifo_wr_valid    = 1'b0;

        case (state)
            ST_IDLE: begin
                if (rx_hdr_valid) begin
                    if (!port_match) begin
                        rx_hdr_ready = 1'b1;
                        state_next   = ST_DISCARD;
                    end else if (hdr_free) begin
                        // Header taken and reply loaded on the same edge
                        rx_hdr_ready = 1'b1;
                        hdr_load     = 1'b1;
                        state_next   = ST_FORWARD;
                    end
                    // Matching header waits while the reply slot is full
                end
            end

            ST_FORWARD: begin
                rx_payload_ready = fifo_wr_ready;
                fifo_wr_valid    = rx_payload_valid;
                if (last_done) begin
                    state_next = ST_IDLE;
                end
            end

            ST_DISCARD: begin
                // Drain the payload of a frame we do not answer
                rx_payload_ready = 1'b1;
                if (last_done) begin
                    state_next = ST_IDLE;
                end
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: udp_reply_header.sv
// UDP reply header register
`default_nettype none

module udp_reply_header
    import udp_echo_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    // Load from the controller
    input  wire logic     load,
    input  wire udp_hdr_t rx_hdr,
    output logic          free,

    // Reply header channel
    output udp_hdr_t      tx_hdr,
    output logic          tx_hdr_valid,
    input  wire logic     tx_hdr_ready
);

    udp_hdr_t hdr_q;
    udp_hdr_t reply;
    logic     valid_q;

    // Swap addresses and ports, answer from our own IP
    always_comb begin
        reply.src_ip    = LOCAL_IP;
        reply.dest_ip   = rx_hdr.src_ip;
        reply.src_port  = rx_hdr.dest_port;
        reply.dest_port = rx_hdr.src_port;
        reply.length    = rx_hdr.length;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hdr_q <= reply;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (load) begin
            // Also covers a load on the edge of the previous transfer
            valid_q <= 1'b1;
        end else if (tx_hdr_ready) begin
            valid_q <= 1'b0;
        end
    end

    // Empty, or emptied by a transfer this cycle
    assign free = !valid_q || tx_hdr_ready;

    assign tx_hdr       = hdr_q;
    assign tx_hdr_valid = valid_q;

endmodule

`default_nettype wire

// File: udp_payload_fifo.sv
// Echo payload FIFO
`default_nettype none

module udp_payload_fifo
    import udp_echo_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    // Write side
    input  wire axis_beat_t wr_beat,
    input  wire logic       wr_valid,
    output logic            wr_ready,

    // Read side
    output axis_beat_t      rd_beat,
    output logic            rd_valid,
    input  wire logic       rd_ready
);

    axis_beat_t mem [FIFO_DEPTH];

    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_ADDR_W:0]   count;
    logic                   wr_en;
    logic                   rd_en;

    // Full at FIFO_DEPTH entries, empty at zero
    assign wr_ready = (count != (FIFO_ADDR_W+1)'(FIFO_DEPTH));
    assign rd_valid = (count != '0);

    assign wr_en = wr_valid && wr_ready;
    assign rd_en = rd_valid && rd_ready;

    // Head entry shows directly on the output
    assign rd_beat = mem[rd_ptr];

    // Storage, flags travel with each byte
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // Pointers wrap naturally at a power of two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on a simultaneous read and write
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: udp_echo_pkg.sv
// UDP echo shared types
`default_nettype none

package udp_echo_pkg;

    // Field widths
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  byte_t;

    // Parsed UDP header, same layout for receive and reply
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dest_ip;
        udp_port_t src_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_hdr_t;

    // One payload byte with its frame flags
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } axis_beat_t;

    // Per-frame steering
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FORWARD,
        ST_DISCARD
    } echo_state_t;

    // Our address, 192.168.1.128
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Only this port is answered
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Payload buffer
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire
